/* tb.f */
hw/rv_div_pkg.sv
hw/div_operand_cond.sv
hw/div_restoring_array.sv
hw/div_result_fix.sv
hw/rv_div_unit.sv
test/div_checker.sv
test/tb_rv_div.sv

/* Makefile */
# Verilator flow for the RV32 divide unit and its testbench

RTL = hw/rv_div_pkg.sv hw/div_operand_cond.sv hw/div_restoring_array.sv \
      hw/div_result_fix.sv hw/rv_div_unit.sv
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module rv_div_unit $(RTL)
	verilator --lint-only --timing --top-module tb_rv_div -f tb.f

sim:
	verilator --binary --timing -j 0 --top-module tb_rv_div -f tb.f -Mdir obj_dir -o tb_rv_div
	./obj_dir/tb_rv_div > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "All tests passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_rv_div.sv */
/*
 Testbench for the RV32 divide unit
 Directed corner requests, then seeded random traffic checked by div_checker
*/

module tb_rv_div;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_div_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int NUM_RANDOM   = 3000;
	localparam int DRAIN_LIMIT  = 100;

	logic             clk;
	logic             rst;
	logic             i_valid;
	div_req_t         i_req;
	logic             o_valid;
	div_resp_t        o_resp;

	int               value_errors;
	int               timing_errors;
	int               pending;
	int               timeout_errors;
	integer           seed;
	logic [TAG_W-1:0] next_tag;

	rv_div_unit DUT (
		.clk     (clk),
		.rst     (rst),
		.i_valid (i_valid),
		.i_req   (i_req),
		.o_valid (o_valid),
		.o_resp  (o_resp)
	);

	div_checker u_checker (
		.clk             (clk),
		.rst             (rst),
		.i_req_valid     (i_valid),
		.i_req           (i_req),
		.i_resp_valid    (o_valid),
		.i_resp          (o_resp),
		.o_value_errors  (value_errors),
		.o_timing_errors (timing_errors),
		.o_pending       (pending)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	// Puts one request on the inputs for the next rising edge
	task automatic drive_request(input div_op_e op, input logic [XLEN-1:0] dividend,
			input logic [XLEN-1:0] divisor);
		i_valid        = 1'b1;
		i_req.op       = op;
		i_req.tag      = next_tag;
		i_req.dividend = dividend;
		i_req.divisor  = divisor;
		next_tag       = next_tag + 1'b1;
	endtask

	// About one operand in eight is zero, small, -1 or the most negative value
	task automatic draw_operand(output logic [XLEN-1:0] value);
		logic [31:0] pick;
		pick = $random(seed);
		if (pick[2:0] == 3'd0) begin
			case (pick[4:3])
				2'd0:    value = '0;
				2'd1:    value = XLEN'(pick[8:5]);
				2'd2:    value = '1;
				default: value = {1'b1, {(XLEN-1){1'b0}}};
			endcase
		end else begin
			// A random shift spreads magnitudes so quotients of every width show up
			value = $random(seed);
			value = value >> pick[9:5];
		end
	endtask

	initial begin
		logic [XLEN-1:0] dividend;
		logic [XLEN-1:0] divisor;
		logic [31:0]     pick;
		int              waited;
		seed           = 45849;
		clk            = 1'b0;
		rst            = 1'b1;
		i_valid        = 1'b0;
		i_req          = '0;
		next_tag       = '0;
		timeout_errors = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		//////////////////////////////////////////////////////////////////
		// Corner cases back to back, mixed operations
		//////////////////////////////////////////////////////////////////
		@(negedge clk);
		drive_request(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
		@(negedge clk);
		drive_request(OP_REM, 32'h8000_0000, 32'hffff_ffff);
		@(negedge clk);
		drive_request(OP_DIVU, 32'h1234_5678, 32'h0000_0000);
		@(negedge clk);
		drive_request(OP_REM, 32'hffff_fff9, 32'h0000_0000);
		@(negedge clk);
		drive_request(OP_DIV, 32'hffff_fff9, 32'h0000_0002);
		@(negedge clk);
		drive_request(OP_REM, 32'hffff_fff9, 32'h0000_0002);
		@(negedge clk);
		drive_request(OP_DIV, 32'h0000_0007, 32'hffff_fffe);
		@(negedge clk);
		drive_request(OP_REMU, 32'hffff_fff9, 32'h0000_0010);

		//////////////////////////////////////////////////////////////////
		// Random traffic, valid in about 70 percent of the cycles
		//////////////////////////////////////////////////////////////////
		for (int n = 0; n < NUM_RANDOM; n++) begin
			@(negedge clk);
			pick = $random(seed);
			if (pick[3:0] < 4'd11) begin
				draw_operand(dividend);
				draw_operand(divisor);
				drive_request(div_op_e'(pick[5:4]), dividend, divisor);
			end else begin
				i_valid = 1'b0;
			end
		end
		@(negedge clk);
		i_valid = 1'b0;

		// Let the pipe empty, bounded so a lost response cannot hang the run
		@(posedge clk);
		waited = 0;
		while (pending != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited = waited + 1;
		end
		if (pending != 0) begin
			$display("Timeout: %0d responses still missing after %0d cycles",
				pending, DRAIN_LIMIT);
			timeout_errors = timeout_errors + 1;
		end

		$display("Errors: value %0d, timing %0d, timeout %0d",
			value_errors, timing_errors, timeout_errors);
		if (value_errors + timing_errors + timeout_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* test/div_checker.sv */
/*
 Divide unit checker
 Models every accepted request and matches responses for value, tag, order and latency
*/

module div_checker (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_req_valid,
	input  rv_div_pkg::div_req_t   i_req,
	input  logic                   i_resp_valid,
	input  rv_div_pkg::div_resp_t  i_resp,
	output int                     o_value_errors,
	output int                     o_timing_errors,
	output int                     o_pending
);
	timeunit 1ns;
	timeprecision 1ps;
	import rv_div_pkg::*;

	// One expected response and the cycle its request was taken
	typedef struct packed {
		div_resp_t resp;
		int        cycle;
	} expect_t;

	expect_t exp_q[$];
	int      cycle = 0;
	int      pushed = 0;
	int      popped = 0;
	int      value_errs = 0;
	int      timing_errs = 0;

	assign o_value_errors  = value_errs;
	assign o_timing_errors = timing_errs;
	assign o_pending       = pushed - popped;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [XLEN-1:0] model_result(input div_req_t req);
		logic            is_signed;
		logic            is_rem;
		longint          sa;
		longint          sb;
		logic [XLEN-1:0] quo;
		logic [XLEN-1:0] rem;
		is_signed = (req.op == OP_DIV) || (req.op == OP_REM);
		is_rem    = (req.op == OP_REM) || (req.op == OP_REMU);
		if (req.divisor == '0) begin
			// Zero divisor gives all ones and the dividend, signed or not
			quo = '1;
			rem = req.dividend;
		end else if (is_signed) begin
			// In 64 bits -2^31 / -1 stays in range and its low word wraps
			// back onto the dividend, with a zero remainder
			sa  = longint'($signed(req.dividend));
			sb  = longint'($signed(req.divisor));
			quo = XLEN'(sa / sb);
			rem = XLEN'(sa % sb);
		end else begin
			quo = req.dividend / req.divisor;
			rem = req.dividend % req.divisor;
		end
		return is_rem ? rem : quo;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Request side, sampled where the falling edge drive is stable
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		expect_t entry;
		// Latency counts from the cycle in which the request was driven,
		// which is the cycle this edge closes
		if (!rst && i_req_valid) begin
			entry.resp.tag    = i_req.tag;
			entry.resp.result = model_result(i_req);
			entry.cycle       = cycle;
			exp_q.push_back(entry);
			pushed = pushed + 1;
		end
		cycle = cycle + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Response side, half a cycle after the output register moved
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		expect_t entry;
		int      age;
		if (rst) begin
			if (i_resp_valid) begin
				$display("ERROR at %0t: o_valid high during reset", $time);
				timing_errs = timing_errs + 1;
			end
		end else if (i_resp_valid) begin
			if (exp_q.size() == 0) begin
				$display("ERROR at %0t: o_valid with no request outstanding", $time);
				timing_errs = timing_errs + 1;
			end else begin
				entry  = exp_q.pop_front();
				popped = popped + 1;
				age    = cycle - entry.cycle;
				if (age != DIV_LATENCY) begin
					$display("ERROR at %0t: tag %0h answered after %0d cycles, expected %0d",
						$time, entry.resp.tag, age, DIV_LATENCY);
					timing_errs = timing_errs + 1;
				end
				if (i_resp != entry.resp) begin
					$display("ERROR at %0t: got tag %0h result %08h, expected tag %0h result %08h",
						$time, i_resp.tag, i_resp.result, entry.resp.tag, entry.resp.result);
					value_errs = value_errs + 1;
				end
			end
		end else if (exp_q.size() != 0 && (cycle - exp_q[0].cycle) >= DIV_LATENCY) begin
			// The oldest request has had its slot and o_valid never came
			entry  = exp_q.pop_front();
			popped = popped + 1;
			$display("ERROR at %0t: no response for tag %0h", $time, entry.resp.tag);
			timing_errs = timing_errs + 1;
		end
	end

endmodule

/* hw/rv_div_unit.sv */
/*
 RV32 integer divide unit
 Pipelined DIV, DIVU, REM and REMU with a fixed latency of DIV_LATENCY cycles
*/

module rv_div_unit (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     i_valid,
	input  rv_div_pkg::div_req_t     i_req,
	output logic                     o_valid,
	output rv_div_pkg::div_resp_t    o_resp
);
	import rv_div_pkg::*;

	// Conditioned operands, combinational from the request
	logic            cond_valid;
	logic [XLEN-1:0] cond_dividend;
	logic [XLEN-1:0] cond_divisor;
	div_ctl_t        cond_ctl;

	// Unsigned results leaving the array
	logic            arr_valid;
	logic [XLEN-1:0] arr_quotient;
	logic [XLEN-1:0] arr_remainder;
	div_ctl_t        arr_ctl;

	div_operand_cond u_cond (
		.i_valid    (i_valid),
		.i_req      (i_req),
		.o_valid    (cond_valid),
		.o_dividend (cond_dividend),
		.o_divisor  (cond_divisor),
		.o_ctl      (cond_ctl)
	);

	// Holds ARRAY_LATENCY operations in flight
	div_restoring_array u_array (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (cond_valid),
		.i_dividend  (cond_dividend),
		.i_divisor   (cond_divisor),
		.i_ctl       (cond_ctl),
		.o_valid     (arr_valid),
		.o_quotient  (arr_quotient),
		.o_remainder (arr_remainder),
		.o_ctl       (arr_ctl)
	);

	div_result_fix u_fix (
		.clk         (clk),
		.rst         (rst),
		.i_valid     (arr_valid),
		.i_quotient  (arr_quotient),
		.i_remainder (arr_remainder),
		.i_ctl       (arr_ctl),
		.o_valid     (o_valid),
		.o_resp      (o_resp)
	);

endmodule

/* hw/div_result_fix.sv */
/*
 Divide result correction
 Restores signs, applies the zero divisor rule and registers the chosen result
*/

module div_result_fix (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_valid,
	input  logic [rv_div_pkg::XLEN-1:0]     i_quotient,
	input  logic [rv_div_pkg::XLEN-1:0]     i_remainder,
	input  rv_div_pkg::div_ctl_t            i_ctl,
	output logic                            o_valid,
	output rv_div_pkg::div_resp_t           o_resp
);
	import rv_div_pkg::*;

	logic [XLEN-1:0] quo_fix;
	logic [XLEN-1:0] rem_fix;
	logic [XLEN-1:0] result;

	always_comb begin
		// Zero divisor wants all ones no matter what the signs say
		if (i_ctl.div_zero) begin
			quo_fix = '1;
		end else if (i_ctl.neg_quo) begin
			quo_fix = -i_quotient;
		end else begin
			quo_fix = i_quotient;
		end

		// With a zero divisor the array remainder is the dividend magnitude,
		// so the usual sign fix hands back the original dividend
		if (i_ctl.neg_rem) begin
			rem_fix = -i_remainder;
		end else begin
			rem_fix = i_remainder;
		end

		if (i_ctl.want_rem) begin
			result = rem_fix;
		end else begin
			result = quo_fix;
		end
	end

	// Valid is the only control here
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

	// Payload, only meaningful while o_valid is high
	always_ff @(posedge clk) begin
		o_resp.tag    <= i_ctl.tag;
		o_resp.result <= result;
	end

endmodule

/* hw/div_restoring_array.sv */
/*
 Restoring divider array
 One quotient bit per row, with pipeline registers on the rows given by STAGE_LIST
*/

module div_restoring_array (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            i_valid,
	input  logic [rv_div_pkg::XLEN-1:0]     i_dividend,
	input  logic [rv_div_pkg::XLEN-1:0]     i_divisor,
	input  rv_div_pkg::div_ctl_t            i_ctl,
	output logic                            o_valid,
	output logic [rv_div_pkg::XLEN-1:0]     o_quotient,
	output logic [rv_div_pkg::XLEN-1:0]     o_remainder,
	output rv_div_pkg::div_ctl_t            o_ctl
);
	import rv_div_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Row state
	//////////////////////////////////////////////////////////////////////

	// Everything one operation needs at a row boundary
	// The dividend word holds the partial remainder in its top bits and
	// the not yet consumed dividend bits below it
	typedef struct packed {
		logic            valid;
		div_ctl_t        ctl;
		logic [XLEN-1:0] dividend;
		logic [XLEN-1:0] divisor;
		logic [XLEN-1:0] quotient;
	} row_t;

	// Entry 0 is the array input, entry i+1 is the output of row i
	row_t row [XLEN+1];

	always_comb begin
		row[0].valid    = i_valid;
		row[0].ctl      = i_ctl;
		row[0].dividend = i_dividend;
		row[0].divisor  = i_divisor;
		row[0].quotient = '0;
	end

	//////////////////////////////////////////////////////////////////////
	// Divider rows
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < XLEN; i++) begin : gen_row
		// Top i+1 bits of the shifting dividend
		logic [i:0] rem_top;
		// Divisor bits that fit beside rem_top
		logic [i:0] dsr_low;
		// Divisor too wide to fit into i+1 bits
		logic       dsr_high;
		logic       q_bit;
		logic [i:0] diff;
		row_t       nxt;

		always_comb begin
			rem_top  = row[i].dividend[XLEN-1 -: i+1];
			dsr_low  = row[i].divisor[i:0];
			dsr_high = |(row[i].divisor >> (i + 1));

			// Subtract only when the divisor fits under the window
			q_bit = !dsr_high && (rem_top >= dsr_low);
			if (q_bit) begin
				diff = rem_top - dsr_low;
			end else begin
				diff = rem_top;
			end

			// Restore or keep the window, then the next row looks one bit lower
			nxt                             = row[i];
			nxt.dividend[XLEN-1 -: i+1]     = diff;
			nxt.quotient[XLEN-1-i]          = q_bit;
		end

		if (STAGE_LIST[XLEN-1-i]) begin : gen_reg
			// Valid, control and data share this register so that each
			// stage holds one complete operation
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					row[i+1] <= '0;
				end else begin
					row[i+1] <= nxt;
				end
			end
		end else begin : gen_comb
			always_comb begin
				row[i+1] = nxt;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////////////////////////

	// After the last row the whole dividend word is the remainder
	assign o_valid     = row[XLEN].valid;
	assign o_ctl       = row[XLEN].ctl;
	assign o_quotient  = row[XLEN].quotient;
	assign o_remainder = row[XLEN].dividend;

endmodule

/* hw/div_operand_cond.sv */
/*
 Divide operand conditioning
 Decodes the operation and turns signed operands into magnitudes plus sign flags
*/

module div_operand_cond (
	input  logic                            i_valid,
	input  rv_div_pkg::div_req_t            i_req,
	output logic                            o_valid,
	output logic [rv_div_pkg::XLEN-1:0]     o_dividend,
	output logic [rv_div_pkg::XLEN-1:0]     o_divisor,
	output rv_div_pkg::div_ctl_t            o_ctl
);
	import rv_div_pkg::*;

	// Signed forms are DIV and REM
	logic signed_op;

	// Operand signs only count for a signed operation
	logic dvd_neg;
	logic dsr_neg;

	always_comb begin
		signed_op = (i_req.op == OP_DIV) || (i_req.op == OP_REM);
		dvd_neg   = signed_op && i_req.dividend[XLEN-1];
		dsr_neg   = signed_op && i_req.divisor[XLEN-1];
	end

	// Two's complement magnitudes for the unsigned array
	// The most negative value maps onto itself, which the array reads
	// as 2^31 and so gives the right quotient for a divisor of -1
	always_comb begin
		if (dvd_neg) begin
			o_dividend = -i_req.dividend;
		end else begin
			o_dividend = i_req.dividend;
		end
		if (dsr_neg) begin
			o_divisor = -i_req.divisor;
		end else begin
			o_divisor = i_req.divisor;
		end
	end

	// All flags are formed here so that later stages never look at the
	// original operands again
	always_comb begin
		o_ctl.tag      = i_req.tag;
		o_ctl.want_rem = (i_req.op == OP_REM) || (i_req.op == OP_REMU);
		// Quotient is negative when exactly one operand is negative
		o_ctl.neg_quo  = dvd_neg ^ dsr_neg;
		// Remainder takes the sign of the dividend
		o_ctl.neg_rem  = dvd_neg;
		o_ctl.div_zero = (i_req.divisor == '0);
	end

	// No state in this stage, so valid moves straight on
	assign o_valid = i_valid;

endmodule

/* hw/rv_div_pkg.sv */
/*
 RV32 divide unit shared definitions
 Widths, pipeline placement, operation encoding and the structs between stages
*/

package rv_div_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and pipeline shape
	//////////////////////////////////////////////////////////////////////

	// Operand and result width of the core
	localparam int XLEN = 32;

	// Width of the tag that follows each request to its response
	localparam int TAG_W = 4;

	// Bit XLEN-1-i set means divider row i ends in a register
	// Eight set bits, spread so that each stage holds a similar number of rows
	localparam logic [XLEN-1:0] STAGE_LIST = 32'b00001000010000100010001001001001;

	// One cycle per set bit of STAGE_LIST
	localparam int ARRAY_LATENCY = 8;

	// The result register adds one more cycle after the array
	localparam int DIV_LATENCY = ARRAY_LATENCY + 1;

	//////////////////////////////////////////////////////////////////////
	// Operation encoding and stage payloads
	//////////////////////////////////////////////////////////////////////

	// Same order as funct3[1:0] of the M extension divide group
	typedef enum logic [1:0] {
		OP_DIV  = 2'd0,
		OP_DIVU = 2'd1,
		OP_REM  = 2'd2,
		OP_REMU = 2'd3
	} div_op_e;

	// Request as issued by the core
	typedef struct packed {
		div_op_e           op;
		logic [TAG_W-1:0]  tag;
		logic [XLEN-1:0]   dividend;
		logic [XLEN-1:0]   divisor;
	} div_req_t;

	// Control that rides beside the data through every stage
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic              want_rem;
		logic              neg_quo;
		logic              neg_rem;
		logic              div_zero;
	} div_ctl_t;

	// Response handed back to the core
	typedef struct packed {
		logic [TAG_W-1:0]  tag;
		logic [XLEN-1:0]   result;
	} div_resp_t;

endpackage
